/* hdl/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address and block geometry
`define DC_ADDR_BITS      32
`define DC_BLOCK_BITS     64
`define DC_OFFSET_BITS    3

// main cache is direct mapped, 16 lines
`define DC_INDEX_BITS     4

// fully associative victim store
`define DC_VC_LINES       4

// tag carried on the memory bus
`define DC_MEM_TAG_BITS   4

// derived widths
`define DC_TAG_BITS       (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS)
`define DC_LINE_ADDR_BITS (`DC_ADDR_BITS - `DC_OFFSET_BITS)

`endif

/* hdl/dcache_pkg.sv */
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;
    typedef enum logic [1:0] {READY, WAIT_FILL, WRITE_BACK} ctrl_state_t;

    // one 64-bit block seen at three granularities
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } cache_block_t;

    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [`DC_TAG_BITS-1:0]   tag;
        cache_block_t              block;
    } main_line_t;

    typedef struct packed {
        logic                          valid;
        logic                          dirty;
        logic [1:0]                    lru;       // 3 = most recently hit
        logic [`DC_LINE_ADDR_BITS-1:0] line_addr; // address without byte offset
        cache_block_t                  block;
    } victim_line_t;

    function automatic cache_block_t merge_store(
        input cache_block_t                block,
        input logic [`DC_OFFSET_BITS-1:0]  offset,
        input mem_size_t                   size,
        input logic [31:0]                 data
    );
        cache_block_t merged;
        merged = block;
        case (size)
            BYTE:    merged.bytes[offset] = data[7:0];
            HALF:    merged.halves[offset[2:1]] = data[15:0];
            default: merged.words[offset[2]] = data;
        endcase
        return merged;
    endfunction

    // zero extended, misaligned low bits ignored
    function automatic logic [31:0] extract_load(
        input cache_block_t                block,
        input logic [`DC_OFFSET_BITS-1:0]  offset,
        input mem_size_t                   size
    );
        logic [31:0] value;
        case (size)
            BYTE:    value = {24'b0, block.bytes[offset]};
            HALF:    value = {16'b0, block.halves[offset[2:1]]};
            default: value = block.words[offset[2]];
        endcase
        return value;
    endfunction

endpackage

`default_nettype wire

/* hdl/dcache_ifs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

// request path from the controller into one cache
interface cache_port_if import dcache_pkg::*; ();
    logic                     valid;
    mem_op_t                  op;
    mem_size_t                size;
    logic [`DC_ADDR_BITS-1:0] addr;
    logic [31:0]              wdata;
    logic                     hit;   // decided by the cache alone
    cache_block_t             block; // block of the matching line

    modport controller (output valid, op, size, addr, wdata, input hit, block);
    modport cache (input valid, op, size, addr, wdata, output hit, block);
endinterface

// single-cycle strobe carrying one whole line
interface line_xfer_if import dcache_pkg::*; ();
    logic                          valid;
    logic                          dirty;
    logic [`DC_LINE_ADDR_BITS-1:0] addr; // line address, no byte offset
    cache_block_t                  block;

    modport sender (output valid, dirty, addr, block);
    modport receiver (input valid, dirty, addr, block);
endinterface

`default_nettype wire

/* hdl/main_cache_array.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module main_cache_array import dcache_pkg::*; (
    input wire logic        clock,
    input wire logic        reset,
    cache_port_if.cache     lookup,
    line_xfer_if.receiver   fill,
    line_xfer_if.sender     evict
);

    localparam int LINES = 2 ** `DC_INDEX_BITS;

    main_line_t lines [LINES];

    logic [`DC_INDEX_BITS-1:0]  lookup_index;
    logic [`DC_TAG_BITS-1:0]    lookup_tag;
    logic [`DC_OFFSET_BITS-1:0] lookup_offset;
    main_line_t                 lookup_line;
    logic [`DC_INDEX_BITS-1:0]  fill_index;
    main_line_t                 fill_old;   // line displaced by the fill

    assign lookup_offset = lookup.addr[`DC_OFFSET_BITS-1:0];
    assign lookup_index  = lookup.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign lookup_tag    = lookup.addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
    assign lookup_line   = lines[lookup_index];

    assign lookup.hit   = lookup.valid && lookup_line.valid && (lookup_line.tag == lookup_tag);
    assign lookup.block = lookup_line.block;

    // fill address is a line address, so index sits in the low bits
    assign fill_index = fill.addr[`DC_INDEX_BITS-1:0];
    assign fill_old   = lines[fill_index];

    assign evict.valid = fill.valid && fill_old.valid;
    assign evict.dirty = fill_old.dirty;
    assign evict.addr  = {fill_old.tag, fill_index}; // rebuild line address
    assign evict.block = fill_old.block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (fill.valid) begin
            lines[fill_index].valid <= 1'b1;
            lines[fill_index].dirty <= fill.dirty;
            lines[fill_index].tag   <= fill.addr[`DC_LINE_ADDR_BITS-1:`DC_INDEX_BITS];
            lines[fill_index].block <= fill.block;
        end else if (lookup.hit && lookup.op == MEM_WRITE) begin
            // store hit: merge in place, line now differs from memory
            lines[lookup_index].dirty <= 1'b1;
            lines[lookup_index].block <= merge_store(lookup_line.block, lookup_offset,
                                                     lookup.size, lookup.wdata);
        end
    end

endmodule

`default_nettype wire

/* hdl/victim_cache.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module victim_cache import dcache_pkg::*; (
    input wire logic        clock,
    input wire logic        reset,
    cache_port_if.cache     lookup,
    line_xfer_if.receiver   insert,
    line_xfer_if.sender     writeback
);

    localparam int IW = $clog2(`DC_VC_LINES);

    victim_line_t lines [`DC_VC_LINES];

    logic                       match;
    logic [IW-1:0]              hit_index;
    logic                       has_free;
    logic [IW-1:0]              free_index;
    logic [IW-1:0]              lru_index;
    logic [1:0]                 min_lru;
    logic [IW-1:0]              insert_index;
    logic [`DC_OFFSET_BITS-1:0] lookup_offset;

    assign lookup_offset = lookup.addr[`DC_OFFSET_BITS-1:0];

    // parallel compare against every line
    always_comb begin
        match     = 1'b0;
        hit_index = '0;
        for (int i = 0; i < `DC_VC_LINES; i++) begin
            if (!match && lines[i].valid &&
                lines[i].line_addr == lookup.addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS]) begin
                match     = 1'b1;
                hit_index = IW'(i);
            end
        end
    end

    assign lookup.hit   = lookup.valid && match;
    assign lookup.block = lines[hit_index].block;

    // slot for an incoming line: first free one, else lowest lru
    always_comb begin
        has_free   = 1'b0;
        free_index = '0;
        lru_index  = '0;
        min_lru    = lines[0].lru;
        for (int i = 0; i < `DC_VC_LINES; i++) begin
            if (!has_free && !lines[i].valid) begin
                has_free   = 1'b1;
                free_index = IW'(i);
            end
            if (lines[i].lru < min_lru) begin // strict, so ties keep the lower index
                min_lru   = lines[i].lru;
                lru_index = IW'(i);
            end
        end
    end

    assign insert_index = has_free ? free_index : lru_index;

    // clean victims are simply dropped
    assign writeback.valid = insert.valid && !has_free && lines[lru_index].dirty;
    assign writeback.dirty = lines[lru_index].dirty;
    assign writeback.addr  = lines[lru_index].line_addr;
    assign writeback.block = lines[lru_index].block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_VC_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].lru   <= 2'd0;
            end
        end else if (insert.valid) begin
            lines[insert_index] <= '{valid: 1'b1, dirty: insert.dirty, lru: 2'd0,
                                     line_addr: insert.addr, block: insert.block};
        end else if (lookup.hit) begin
            for (int i = 0; i < `DC_VC_LINES; i++) begin
                if (IW'(i) == hit_index) begin
                    lines[i].lru <= 2'd3;
                end else if (lines[i].lru != 2'd0) begin
                    lines[i].lru <= lines[i].lru - 2'd1;
                end
            end
            if (lookup.op == MEM_WRITE) begin
                lines[hit_index].dirty <= 1'b1;
                lines[hit_index].block <= merge_store(lines[hit_index].block, lookup_offset,
                                                      lookup.size, lookup.wdata);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/miss_controller.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module miss_controller import dcache_pkg::*; (
    input wire logic                        clock,
    input wire logic                        reset,
    input wire logic                        req_valid,
    input wire mem_op_t                     req_op,
    input wire mem_size_t                   req_size,
    input wire logic [`DC_ADDR_BITS-1:0]    req_addr,
    input wire logic [31:0]                 req_wdata,
    output logic                            stall,
    output logic                            resp_valid,
    output logic [31:0]                     resp_rdata,
    cache_port_if.controller                main_port,
    cache_port_if.controller                victim_port,
    line_xfer_if.sender                     fill,
    line_xfer_if.receiver                   writeback,
    input wire logic [`DC_MEM_TAG_BITS-1:0] mem_response,
    input wire logic [`DC_MEM_TAG_BITS-1:0] mem_tag,
    input wire logic [`DC_BLOCK_BITS-1:0]   mem_data,
    output bus_cmd_t                        mem_command,
    output logic [`DC_ADDR_BITS-1:0]        mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]       mem_wdata
);

    ctrl_state_t state, next_state;

    logic                          lookup_valid;
    logic                          any_hit;
    cache_block_t                  hit_block;
    logic [`DC_LINE_ADDR_BITS-1:0] miss_addr;  // miss register
    logic [`DC_MEM_TAG_BITS-1:0]   miss_tag;   // zero until the load is accepted
    logic [`DC_LINE_ADDR_BITS-1:0] wb_addr;    // one-entry write-back buffer
    cache_block_t                  wb_block;
    logic                          fill_now;

    assign lookup_valid = (state == READY) && req_valid;

    // same request goes to both caches
    assign main_port.valid   = lookup_valid;
    assign main_port.op      = req_op;
    assign main_port.size    = req_size;
    assign main_port.addr    = req_addr;
    assign main_port.wdata   = req_wdata;
    assign victim_port.valid = lookup_valid;
    assign victim_port.op    = req_op;
    assign victim_port.size  = req_size;
    assign victim_port.addr  = req_addr;
    assign victim_port.wdata = req_wdata;

    assign any_hit   = main_port.hit || victim_port.hit;
    assign hit_block = main_port.hit ? main_port.block : victim_port.block;
    assign stall     = (state != READY);

    assign fill_now   = (state == WAIT_FILL) && (miss_tag != '0) && (mem_tag == miss_tag);
    assign fill.valid = fill_now;
    assign fill.dirty = 1'b0; // fresh from memory
    assign fill.addr  = miss_addr;
    assign fill.block = mem_data;

    always_comb begin
        next_state  = state;
        mem_command = BUS_NONE;
        mem_addr    = '0;
        mem_wdata   = '0;
        case (state)
            READY: begin
                if (req_valid && !any_hit) next_state = WAIT_FILL;
            end
            WAIT_FILL: begin
                mem_addr = {miss_addr, {`DC_OFFSET_BITS{1'b0}}};
                if (miss_tag == '0) mem_command = BUS_LOAD; // hold until accepted
                if (fill_now) begin
                    next_state = (writeback.valid && writeback.dirty) ? WRITE_BACK : READY;
                end
            end
            WRITE_BACK: begin
                mem_command = BUS_STORE;
                mem_addr    = {wb_addr, {`DC_OFFSET_BITS{1'b0}}};
                mem_wdata   = wb_block;
                if (mem_response != '0) next_state = READY;
            end
            default: next_state = READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= READY;
            resp_valid <= 1'b0;
            miss_tag   <= '0;
        end else begin
            state      <= next_state;
            resp_valid <= lookup_valid && any_hit;
            if (state == READY && next_state == WAIT_FILL) begin
                miss_tag <= '0;
            end else if (state == WAIT_FILL && miss_tag == '0 && mem_response != '0) begin
                miss_tag <= mem_response;
            end
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        resp_rdata <= extract_load(hit_block, req_addr[`DC_OFFSET_BITS-1:0], req_size);
        if (state == READY && next_state == WAIT_FILL) begin
            miss_addr <= req_addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS];
        end
        if (writeback.valid) begin
            wb_addr  <= writeback.addr;
            wb_block <= writeback.block;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
    input wire logic                        clock,
    input wire logic                        reset,
    // pipeline side
    input wire logic                        req_valid,
    input wire mem_op_t                     req_op,
    input wire mem_size_t                   req_size,
    input wire logic [`DC_ADDR_BITS-1:0]    req_addr,
    input wire logic [31:0]                 req_wdata,
    output logic                            stall,
    output logic                            resp_valid,
    output logic [31:0]                     resp_rdata,
    // memory bus
    input wire logic [`DC_MEM_TAG_BITS-1:0] mem_response,
    input wire logic [`DC_MEM_TAG_BITS-1:0] mem_tag,
    input wire logic [`DC_BLOCK_BITS-1:0]   mem_data,
    output bus_cmd_t                        mem_command,
    output logic [`DC_ADDR_BITS-1:0]        mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]       mem_wdata
);

    cache_port_if main_port ();
    cache_port_if victim_port ();
    line_xfer_if  fill_xfer ();   // controller to main cache
    line_xfer_if  evict_xfer ();  // main cache to victim cache
    line_xfer_if  wb_xfer ();     // victim cache to controller

    main_cache_array main_cache_array_i (
        .clock  (clock),
        .reset  (reset),
        .lookup (main_port),
        .fill   (fill_xfer),
        .evict  (evict_xfer)
    );

    victim_cache victim_cache_i (
        .clock     (clock),
        .reset     (reset),
        .lookup    (victim_port),
        .insert    (evict_xfer),
        .writeback (wb_xfer)
    );

    miss_controller miss_controller_i (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .stall        (stall),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .main_port    (main_port),
        .victim_port  (victim_port),
        .fill         (fill_xfer),
        .writeback    (wb_xfer),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

`default_nettype wire

/* testbench/dcache_sva.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_sva import dcache_pkg::*; (
    input wire logic                        clock,
    input wire logic                        reset,
    input wire logic                        resp_valid,
    input wire bus_cmd_t                    mem_command,
    input wire logic [`DC_ADDR_BITS-1:0]    mem_addr,
    input wire logic [`DC_BLOCK_BITS-1:0]   mem_wdata,
    input wire logic [`DC_MEM_TAG_BITS-1:0] mem_response,
    input wire logic                        main_hit,
    input wire logic                        victim_hit
);

    int failures = 0; // read by the testbench at the end of the run

    // a command not yet accepted keeps its address and data
    command_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command != BUS_NONE && mem_response == '0) |=>
            ($stable(mem_command) && $stable(mem_addr) && $stable(mem_wdata)))
        else begin
            failures = failures + 1;
            $error("memory command changed before it was accepted");
        end

    // a block lives in one of the two caches only
    single_hit: assert property (@(posedge clock) disable iff (reset)
        !(main_hit && victim_hit))
        else begin
            failures = failures + 1;
            $error("main cache and victim cache hit together");
        end

    response_pulse: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> !resp_valid)
        else begin
            failures = failures + 1;
            $error("resp_valid lasted more than one cycle");
        end

endmodule

bind dcache_top dcache_sva dcache_sva_i (
    .clock        (clock),
    .reset        (reset),
    .resp_valid   (resp_valid),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_response (mem_response),
    .main_hit     (main_port.hit),
    .victim_hit   (victim_port.hit)
);

`default_nettype wire

/* testbench/dcache_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED           = 32'h8d8f_2f6a;
    localparam logic [31:0] PATTERN_KEY    = 32'h5a3c_96e1; // unwritten word = addr ^ key

    logic                        clock = 1'b0;
    logic                        reset;
    logic                        req_valid;
    mem_op_t                     req_op;
    mem_size_t                   req_size;
    logic [`DC_ADDR_BITS-1:0]    req_addr;
    logic [31:0]                 req_wdata;
    logic                        stall;
    logic                        resp_valid;
    logic [31:0]                 resp_rdata;
    logic [`DC_MEM_TAG_BITS-1:0] mem_response = '0;
    logic [`DC_MEM_TAG_BITS-1:0] mem_tag      = '0;
    logic [`DC_BLOCK_BITS-1:0]   mem_data     = '0;
    bus_cmd_t                    mem_command;
    logic [`DC_ADDR_BITS-1:0]    mem_addr;
    logic [`DC_BLOCK_BITS-1:0]   mem_wdata;

    // memory model state
    logic [63:0]                 mem_blocks [logic [31:0]];
    logic [31:0]                 wb_addr_q [$];
    logic [63:0]                 wb_data_q [$];
    int                          load_count   = 0;
    int                          store_count  = 0;
    logic [`DC_MEM_TAG_BITS-1:0] next_tag     = `DC_MEM_TAG_BITS'(1);
    logic                        load_pending = 1'b0;
    int                          load_delay   = 0;
    logic [`DC_MEM_TAG_BITS-1:0] load_tag     = '0;
    logic [31:0]                 load_addr    = '0;
    int                          accept_wait  = 0; // cycles a command is held off
    int                          accept_held  = 0;

    logic [7:0] shadow [logic [31:0]]; // bytes the processor should read back
    string      current_test = "none";

    dcache_top dcache_top_i (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .stall        (stall),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ PATTERN_KEY;
    endfunction

    function automatic logic [63:0] memory_block(input logic [31:0] block_addr);
        logic [63:0] block;
        if (mem_blocks.exists(block_addr)) begin
            block = mem_blocks[block_addr];
        end else begin
            block = {pattern_word(block_addr + 32'd4), pattern_word(block_addr)};
        end
        return block;
    endfunction

    // commands are accepted after accept_wait cycles, load data follows three cycles later
    always @(negedge clock) begin
        mem_response <= '0;
        mem_tag      <= '0;
        if (load_pending) begin
            if (load_delay == 1) begin
                mem_tag      <= load_tag;
                mem_data     <= memory_block(load_addr);
                load_pending <= 1'b0;
            end else begin
                load_delay <= load_delay - 1;
            end
        end
        if (mem_command != BUS_NONE && accept_held < accept_wait) begin
            accept_held <= accept_held + 1; // back-pressure, response stays zero
        end else if (mem_command != BUS_NONE) begin
            accept_held  <= 0;
            mem_response <= next_tag;
            next_tag     <= (next_tag == '1) ? `DC_MEM_TAG_BITS'(1) : next_tag + 1'b1;
            if (mem_command == BUS_LOAD) begin
                load_pending <= 1'b1;
                load_delay   <= 3;
                load_tag     <= next_tag;
                load_addr    <= mem_addr;
                load_count   <= load_count + 1;
            end else begin
                mem_blocks[mem_addr] = mem_wdata;
                wb_addr_q.push_back(mem_addr);
                wb_data_q.push_back(mem_wdata);
                store_count <= store_count + 1;
            end
        end
    end

    function automatic logic [7:0] expected_byte(input logic [31:0] addr);
        logic [31:0] word;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        word = pattern_word(addr) >> (8 * addr[1:0]);
        return word[7:0];
    endfunction

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // little endian, zero extended
    function automatic logic [31:0] expected_read(input logic [31:0] addr, input mem_size_t size);
        logic [31:0] value;
        value = '0;
        for (int i = size_bytes(size) - 1; i >= 0; i--) begin
            value = {value[23:0], expected_byte(addr + 32'(i))};
        end
        return value;
    endfunction

    function automatic logic [63:0] expected_block(input logic [31:0] block_addr);
        logic [63:0] block;
        for (int i = 0; i < 8; i++) begin
            block[8*i +: 8] = expected_byte(block_addr + 32'(i));
        end
        return block;
    endfunction

    task automatic record_store(input logic [31:0] addr, input mem_size_t size,
                                input logic [31:0] data);
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[addr + 32'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error in %s, %s: expected %h, actual %h",
                     current_test, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
    endtask

    // request held until resp_valid, cycles counts falling edges until then
    task automatic access(input mem_op_t op, input mem_size_t size, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int cycles);
        int waited;
        @(negedge clock);
        req_valid = 1'b1;
        req_op    = op;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        waited    = 0;
        do begin
            @(negedge clock);
            waited = waited + 1;
            if (waited > TIMEOUT_CYCLES) begin
                $display("timeout: no response to the request at address %h", addr);
                stop_on_failure();
            end
            if (waited == 1) begin
                // the cycle after a request either answers or stalls
                check("stall or response", 64'(1), 64'(stall ^ resp_valid));
            end
        end while (!resp_valid);
        req_valid = 1'b0;
        rdata     = resp_rdata;
        cycles    = waited;
        if (op == MEM_WRITE) record_store(addr, size, wdata);
    endtask

    task automatic load_data(input mem_size_t size, input logic [31:0] addr,
                             output logic [31:0] rdata, output int cycles);
        access(MEM_READ, size, addr, 32'd0, rdata, cycles);
    endtask

    task automatic store_data(input mem_size_t size, input logic [31:0] addr,
                              input logic [31:0] data);
        logic [31:0] unused;
        int          cycles;
        access(MEM_WRITE, size, addr, data, unused, cycles);
    endtask

    task automatic load_and_compare(input string what, input mem_size_t size,
                                    input logic [31:0] addr);
        logic [31:0] data;
        int          cycles;
        load_data(size, addr, data, cycles);
        check(what, 64'(expected_read(addr, size)), 64'(data));
    endtask

    task automatic test_reset_state();
        current_test = "reset_state";
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            check("stall", 64'(1'b0), 64'(stall));
            check("resp_valid", 64'(1'b0), 64'(resp_valid));
            check("mem_command", 64'(BUS_NONE), 64'(mem_command));
            @(negedge clock);
        end
    endtask

    task automatic test_read_miss();
        logic [31:0] addr;
        logic [31:0] data;
        int          cycles;
        int          loads_before;
        int          stores_before;
        current_test = "read_miss";
        apply_reset();
        addr         = 32'h3000_0040;
        loads_before = load_count;
        load_data(WORD, addr, data, cycles);
        check("miss data", 64'(pattern_word(addr)), 64'(data));
        check("loads for the miss", 64'(loads_before + 1), 64'(load_count));
        check("miss stalled", 64'(1'b1), 64'(cycles > 1));
        loads_before  = load_count;
        stores_before = store_count;
        load_data(WORD, addr + 32'd4, data, cycles);
        check("hit data", 64'(pattern_word(addr + 32'd4)), 64'(data));
        check("hit latency", 64'(1), 64'(cycles));
        check("loads for the hit", 64'(loads_before), 64'(load_count));
        check("stores for the hit", 64'(stores_before), 64'(store_count));
    endtask

    task automatic test_store_merge();
        logic [31:0] base;
        current_test = "store_merge";
        apply_reset();
        base = 32'h2000_0100;
        store_data(BYTE, base + 32'd1, $urandom);   // first one misses
        store_data(HALF, base + 32'd2, $urandom);
        store_data(WORD, base + 32'd4, $urandom);
        store_data(BYTE, base + 32'd7, $urandom);   // overlaps the word
        load_and_compare("word 0", WORD, base);
        load_and_compare("word 1", WORD, base + 32'd4);
        load_and_compare("half 1", HALF, base + 32'd2);
        load_and_compare("byte 7", BYTE, base + 32'd7);
        load_and_compare("byte 0", BYTE, base);
        load_and_compare("half 3", HALF, base + 32'd6);
    endtask

    task automatic test_victim_alternate();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        int          cycles;
        int          loads_before;
        current_test = "victim_alternate";
        apply_reset();
        a = 32'h5000_0018;
        b = 32'h5100_0018; // same index, other tag
        load_and_compare("first block", WORD, a);
        load_and_compare("second block", WORD, b);
        loads_before = load_count;
        for (int i = 0; i < 2; i++) begin
            load_data(WORD, a + 32'd4, data, cycles);
            check("displaced block data", 64'(expected_read(a + 32'd4, WORD)), 64'(data));
            check("victim hit latency", 64'(1), 64'(cycles));
            load_data(WORD, b, data, cycles);
            check("resident block data", 64'(expected_read(b, WORD)), 64'(data));
            check("main hit latency", 64'(1), 64'(cycles));
        end
        store_data(HALF, a + 32'd2, $urandom);
        load_and_compare("store merged in victim", WORD, a);
        check("loads while alternating", 64'(loads_before), 64'(load_count));
    endtask

    task automatic test_victim_overflow();
        logic [31:0] base;
        logic [31:0] block_addr;
        int          loads_before;
        current_test = "victim_overflow";
        apply_reset();
        accept_wait = 2; // memory holds off every command here
        base = 32'h4000_0048; // index 9
        wb_addr_q.delete();
        wb_data_q.delete();
        for (int k = 0; k < 6; k++) begin
            block_addr = base + 32'(k) * 32'h80;
            store_data(WORD, block_addr, $urandom);
            store_data(HALF, block_addr + 32'd6, $urandom);
        end
        check("write-backs after six blocks", 64'(1), 64'(wb_addr_q.size()));
        check("write-back address", 64'(base), 64'(wb_addr_q[0]));
        check("write-back data", expected_block(base), wb_data_q[0]);
        loads_before = load_count;
        load_and_compare("reloaded word", WORD, base);
        load_and_compare("reloaded half", HALF, base + 32'd6);
        check("loads for the reload", 64'(loads_before + 1), 64'(load_count));
        // block 4 is now the oldest victim line
        check("write-backs after the reload", 64'(2), 64'(wb_addr_q.size()));
        check("second write-back address", 64'(base + 32'h200), 64'(wb_addr_q[1]));
        check("second write-back data", expected_block(base + 32'h200), wb_data_q[1]);
        accept_wait = 0;
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = MEM_READ;
        req_size  = WORD;
        req_addr  = '0;
        req_wdata = '0;
        void'($urandom(SEED));
        test_reset_state();
        test_read_miss();
        test_store_merge();
        test_victim_alternate();
        test_victim_overflow();
        if (dcache_top_i.dcache_sva_i.failures == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion failures", dcache_top_i.dcache_sva_i.failures);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_ifs.sv
hdl/main_cache_array.sv
hdl/victim_cache.sv
hdl/miss_controller.sv
hdl/dcache_top.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing --assert

SOURCES := $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
